// File: umode_checker.f
+incdir+verilog
verilog/umode_checker_pkg.sv
verilog/umode_decode.sv
verilog/umode_execute.sv
verilog/umode_result.sv
verilog/umode_checker.sv
verif/tb_clock_gen.sv
verif/umode_checker_props.sv
verif/umode_checker_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f umode_checker.f --top-module umode_checker_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vumode_checker_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF 'All tests passed!'; then
  exit 0
fi
exit 1

// File: verif/umode_checker_tb.sv
`timescale 1ns/1ps
`include "umode_checker_params.svh"

module umode_checker_tb;

  import umode_checker_pkg::*;

  localparam int SEED   = 96097;
  localparam int CLK_NS = 40;
  // 21 single-record slots of 5 cycles, a 25-cycle burst and the reset
  localparam int TEST_CYCLES = 21 * 5 + 25 + 4;
  localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_NS;
  localparam logic [31:0] ADDI_NOP     = 32'h0000_0013;
  // csrrs x1, medeleg, x0
  localparam logic [31:0] MEDELEG_READ = 32'h3020_20F3;

  logic                 clk_i;
  logic                 rst_ni;
  retire_t              retire;
  logic                 fetch_valid;
  logic [`UMC_XLEN-1:0] fetch_addr;
  logic                 viol_valid;
  rule_vec_t            viol;
  rule_vec_t            sticky;
  count_t               checked_count;

  rule_vec_t exp_sticky;
  count_t    exp_count;
  int        errors;
  int        tests_run;
  int        tests_failed;
  int        test_err_start;

  tb_clock_gen #(.HALF_PERIOD_NS(CLK_NS / 2), .RESET_CYCLES(3)) u_clock_gen (
    .clk_i  (clk_i),
    .rst_ni (rst_ni)
  );

  umode_checker u_umode_checker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .retire        (retire),
    .fetch_valid   (fetch_valid),
    .fetch_addr    (fetch_addr),
    .viol_valid    (viol_valid),
    .viol          (viol),
    .sticky        (sticky),
    .checked_count (checked_count)
  );

  bind umode_checker umode_checker_props u_props (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .viol_valid    (viol_valid),
    .viol          (viol),
    .sticky        (sticky),
    .checked_count (checked_count)
  );

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_rules(input string name, input rule_vec_t got, input rule_vec_t exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%03h expected 0x%03h", name, got, exp);
      errors++;
    end
  endtask

  task automatic match_count(input string name, input count_t got, input count_t exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%04h expected 0x%04h", name, got, exp);
      errors++;
    end
  endtask

  function automatic rule_vec_t only_rule(input rule_e r);
    rule_vec_t v;
    v    = '0;
    v[r] = 1'b1;
    return v;
  endfunction

  // Plain ADDI retirement with a legal misa and a zero mstatus
  function automatic retire_t clean_record(input mode_t mode, input logic [`UMC_XLEN-1:0] pc);
    retire_t rec;
    rec                   = '0;
    rec.valid             = 1'b1;
    rec.mode              = mode;
    rec.insn              = ADDI_NOP;
    rec.pc                = pc;
    rec.misa[`UMC_MISA_U] = 1'b1;
    return rec;
  endfunction

  function automatic retire_t with_trap(input retire_t rec, input logic [5:0] cause);
    retire_t r;
    r                = rec;
    r.trap.valid     = 1'b1;
    r.trap.exception = 1'b1;
    r.trap.cause     = cause;
    return r;
  endfunction

  // One record in its own slot, with an optional fetch in the cycle before
  task automatic play_record(input retire_t rec, input logic do_fetch,
                             input logic [`UMC_XLEN-1:0] fetch_pc, input rule_vec_t exp_viol);
    @(posedge clk_i);
    fetch_valid <= do_fetch;
    fetch_addr  <= fetch_pc;
    @(posedge clk_i);
    retire      <= rec;
    fetch_valid <= 1'b0;
    @(posedge clk_i);
    retire.valid <= 1'b0;
    // Result register loads two edges after the record is sampled
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    exp_sticky = exp_sticky | exp_viol;
    exp_count  = exp_count + count_t'(1);
    check_flag("viol_valid", viol_valid, |exp_viol);
    compare_rules("viol", viol, exp_viol);
    compare_rules("sticky", sticky, exp_sticky);
    match_count("checked_count", checked_count, exp_count);
  endtask

  task automatic fetched_record(input retire_t rec, input rule_vec_t exp_viol);
    play_record(rec, 1'b1, rec.pc, exp_viol);
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == test_err_start) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, errors - test_err_start);
    end
    test_err_start = errors;
  endtask

  task automatic reset_test();
    check_flag("viol_valid", viol_valid, 1'b0);
    compare_rules("viol", viol, '0);
    compare_rules("sticky", sticky, '0);
    match_count("checked_count", checked_count, '0);
    report_test("reset");
  endtask

  task automatic static_test();
    retire_t rec;
    rec = clean_record(`UMC_MODE_M, 32'h100);
    rec.misa[`UMC_MISA_S] = 1'b1;
    fetched_record(rec, only_rule(RULE_MISA));
    rec = clean_record(`UMC_MODE_M, 32'h104);
    rec.mstatus_rdata[`UMC_MSTATUS_MPP] = 2'b10;
    fetched_record(rec, only_rule(RULE_STATUS));
    rec = clean_record(`UMC_MODE_U, 32'h200);
    rec.mscratch_wmask = 32'hFFFF_FFFF;
    fetched_record(rec, only_rule(RULE_MSCRATCH));
    report_test("static");
  endtask

  task automatic illegal_test();
    retire_t rec;
    rec      = clean_record(`UMC_MODE_M, 32'h300);
    rec.insn = `UMC_CUSTOM0;
    fetched_record(rec, only_rule(RULE_ILLEGAL));
    rec      = clean_record(`UMC_MODE_U, 32'h400);
    rec.insn = MEDELEG_READ;
    fetched_record(rec, only_rule(RULE_ILLEGAL));
    rec      = with_trap(rec, `UMC_EXC_ILLEGAL_INSN);
    rec.pc   = 32'h404;
    fetched_record(rec, '0);
    fetched_record(clean_record(`UMC_MODE_M, 32'h500), '0);
    rec      = with_trap(clean_record(`UMC_MODE_M, 32'h504), `UMC_EXC_ILLEGAL_INSN);
    rec.insn = `UMC_CUSTOM1;
    fetched_record(rec, '0);
    fetched_record(clean_record(`UMC_MODE_M, 32'h508), '0);
    // WFI from U with TW clear has to execute
    rec      = with_trap(clean_record(`UMC_MODE_U, 32'h600), `UMC_EXC_ILLEGAL_INSN);
    rec.insn = `UMC_INSN_WFI;
    fetched_record(rec, only_rule(RULE_WFI_OK));
    report_test("illegal");
  endtask

  task automatic cross_test();
    retire_t rec;
    fetched_record(clean_record(`UMC_MODE_M, 32'h700), '0);
    rec = with_trap(clean_record(`UMC_MODE_M, 32'h704), `UMC_EXC_ILLEGAL_INSN);
    fetched_record(rec, '0);
    fetched_record(clean_record(`UMC_MODE_U, 32'h800), only_rule(RULE_TRAP_MMODE));
    // MRET to U that clears MPRV through the write mask
    rec      = clean_record(`UMC_MODE_M, 32'h900);
    rec.insn = `UMC_INSN_MRET;
    rec.mstatus_rdata[`UMC_MSTATUS_MPRV] = 1'b1;
    rec.mstatus_wmask[`UMC_MSTATUS_MPRV] = 1'b1;
    fetched_record(rec, '0);
    fetched_record(clean_record(`UMC_MODE_U, 32'hA00), '0);
    rec.pc = 32'h904;
    fetched_record(rec, '0);
    fetched_record(clean_record(`UMC_MODE_M, 32'h908), only_rule(RULE_MRET_MODE));
    report_test("cross");
  endtask

  task automatic refetch_test();
    fetched_record(clean_record(`UMC_MODE_U, 32'hB00), '0);
    play_record(clean_record(`UMC_MODE_M, 32'hC00), 1'b0, 32'hC00, only_rule(RULE_REFETCH));
    play_record(clean_record(`UMC_MODE_U, 32'hD00), 1'b1, 32'hD40, only_rule(RULE_REFETCH));
    fetched_record(clean_record(`UMC_MODE_M, 32'hE00), '0);
    report_test("refetch");
  endtask

  // Back-to-back clean M-mode ADDI records
  task automatic burst_test();
    retire_t rec;
    int      i;
    for (i = 0; i < 20; i++) begin
      rec      = clean_record(`UMC_MODE_M, $urandom & 32'hFFFF_FFFC);
      rec.insn = {12'($urandom), 5'($urandom), 3'b000, 5'($urandom), 7'b0010011};
      rec.misa = $urandom;
      rec.misa[`UMC_MISA_U] = 1'b1;
      rec.misa[`UMC_MISA_S] = 1'b0;
      rec.misa[`UMC_MISA_N] = 1'b0;
      @(posedge clk_i);
      retire <= rec;
      @(negedge clk_i);
      check_flag("viol_valid", viol_valid, 1'b0);
    end
    @(posedge clk_i);
    retire.valid <= 1'b0;
    repeat (4) begin
      @(negedge clk_i);
      check_flag("viol_valid", viol_valid, 1'b0);
    end
    exp_count = exp_count + count_t'(20);
    match_count("checked_count", checked_count, exp_count);
    compare_rules("sticky", sticky, exp_sticky);
    report_test("burst");
  endtask

  initial begin
    void'($urandom(SEED));
    retire         <= '0;
    fetch_valid    <= 1'b0;
    fetch_addr     <= '0;
    exp_sticky     = '0;
    exp_count      = '0;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    test_err_start = 0;
    @(posedge rst_ni);
    @(negedge clk_i);
    reset_test();
    static_test();
    illegal_test();
    cross_test();
    refetch_test();
    burst_test();
    $display("Summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: verif/umode_checker_props.sv
`timescale 1ns/1ps

module umode_checker_props (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         viol_valid,
  input umode_checker_pkg::rule_vec_t viol,
  input umode_checker_pkg::rule_vec_t sticky,
  input umode_checker_pkg::count_t    checked_count
);

  import umode_checker_pkg::*;

  // Outputs come out of reset cleared
  reset_clears: assert property (@(posedge clk_i)
    !rst_ni |=> (!viol_valid && (viol == '0) && (sticky == '0) && (checked_count == '0)))
    else $error("outputs not cleared after reset");

  pulse_matches_vector: assert property (@(posedge clk_i) disable iff (!rst_ni)
    viol_valid == (|viol))
    else $error("viol_valid disagrees with viol");

  viol_in_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (viol & ~sticky) == '0)
    else $error("reported rule missing from sticky");

  // Sticky flags never clear outside reset
  sticky_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) |-> (($past(sticky) & ~sticky) == '0))
    else $error("sticky flag dropped");

  count_steps: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) |-> ((checked_count - $past(checked_count)) <= count_t'(1)))
    else $error("checked_count moved by more than one");

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 20,
  parameter int RESET_CYCLES   = 3
) (
  output logic clk_i,
  output logic rst_ni
);

  initial begin
    clk_i = 1'b0;
    forever #(HALF_PERIOD_NS) clk_i = ~clk_i;
  end

  // Reset held low over the first rising edges
  initial begin
    rst_ni <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
  end

endmodule

// File: verilog/umode_checker.sv
`timescale 1ns/1ps
`include "umode_checker_params.svh"

module umode_checker (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  umode_checker_pkg::retire_t   retire,
  input  logic                         fetch_valid,
  input  logic [`UMC_XLEN-1:0]         fetch_addr,
  output logic                         viol_valid,
  output umode_checker_pkg::rule_vec_t viol,
  output umode_checker_pkg::rule_vec_t sticky,
  output umode_checker_pkg::count_t    checked_count
);

  import umode_checker_pkg::*;

  decoded_t decoded;
  verdict_t verdict;

  // Classify the record and track fetches
  umode_decode u_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .retire      (retire),
    .fetch_valid (fetch_valid),
    .fetch_addr  (fetch_addr),
    .decoded     (decoded)
  );

  umode_execute u_execute (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .decoded (decoded),
    .verdict (verdict)
  );

  umode_result u_result (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .verdict       (verdict),
    .viol_valid    (viol_valid),
    .viol          (viol),
    .sticky        (sticky),
    .checked_count (checked_count)
  );

endmodule

// File: verilog/umode_result.sv
`timescale 1ns/1ps

module umode_result (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  umode_checker_pkg::verdict_t  verdict,
  output logic                         viol_valid,
  output umode_checker_pkg::rule_vec_t viol,
  output umode_checker_pkg::rule_vec_t sticky,
  output umode_checker_pkg::count_t    checked_count
);

  // Rules are already zero on invalid verdicts
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      viol_valid <= 1'b0;
      viol       <= '0;
    end else begin
      viol_valid <= verdict.valid && (|verdict.rules);
      viol       <= verdict.rules;
    end
  end

  // Failures seen since reset
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sticky <= '0;
    end else begin
      sticky <= sticky | verdict.rules;
    end
  end

  // Checked records, holds at all ones
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      checked_count <= '0;
    end else if (verdict.valid && (checked_count != '1)) begin
      checked_count <= checked_count + 1'b1;
    end
  end

endmodule

// File: verilog/umode_execute.sv
`timescale 1ns/1ps
`include "umode_checker_params.svh"

module umode_execute (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  umode_checker_pkg::decoded_t decoded,
  output umode_checker_pkg::verdict_t verdict
);

  import umode_checker_pkg::*;

  // State of the previous valid record
  logic      prev_seen;
  mode_t     prev_mode;
  logic      prev_trapped;
  logic      prev_mret_m;
  mode_t     prev_mpp;

  logic      in_mmode;
  logic      in_umode;
  logic      mret_from_m;
  rule_vec_t rules_d;

  assign in_mmode    = (decoded.mode == `UMC_MODE_M);
  assign in_umode    = (decoded.mode == `UMC_MODE_U);
  assign mret_from_m = decoded.is_mret && in_mmode && !decoded.trapped;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      prev_seen    <= 1'b0;
      prev_trapped <= 1'b0;
      prev_mret_m  <= 1'b0;
    end else if (decoded.valid) begin
      prev_seen    <= 1'b1;
      prev_trapped <= decoded.trapped;
      prev_mret_m  <= mret_from_m;
    end
  end

  // Only meaningful while prev_seen is set
  always_ff @(posedge clk_i) begin
    if (decoded.valid) begin
      prev_mode <= decoded.mode;
      prev_mpp  <= decoded.mpp;
    end
  end

  always_comb begin
    rules_d = '0;

    // Per-record field checks
    rules_d[RULE_MODE]     = !(decoded.mode inside {`UMC_MODE_U, `UMC_MODE_M});
    rules_d[RULE_MISA]     = !decoded.misa_ok;
    rules_d[RULE_STATUS]   = !decoded.status_ok;
    rules_d[RULE_MSCRATCH] = in_umode && decoded.mscratch_written;

    // Illegal instruction handling
    rules_d[RULE_ILLEGAL]  = decoded.must_be_illegal && !decoded.illegal_trapped;
    rules_d[RULE_WFI_OK]   = decoded.wfi_free && decoded.illegal_trapped;

    // Every trap lands in M-mode
    rules_d[RULE_TRAP_MMODE] = prev_seen && prev_trapped && !in_mmode;

    // MRET resumes in the mode held in MPP before it
    rules_d[RULE_MRET_MODE] = prev_seen && prev_mret_m && !decoded.trapped &&
                              (decoded.mode != prev_mpp);

    // MRET leaves MPP at U and clears MPRV when returning below M
    rules_d[RULE_MRET_STATE] = decoded.is_mret &&
                               ((decoded.post_mpp != `UMC_MODE_U) ||
                                ((decoded.mpp != `UMC_MODE_M) && decoded.post_mprv));

    // A mode change needs a fetch of the new pc first
    rules_d[RULE_REFETCH] = prev_seen && (decoded.mode != prev_mode) && !decoded.refetched;

    if (!decoded.valid) begin
      rules_d = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      verdict <= '0;
    end else begin
      verdict.valid <= decoded.valid;
      verdict.rules <= rules_d;
    end
  end

endmodule

// File: verilog/umode_decode.sv
`timescale 1ns/1ps
`include "umode_checker_params.svh"

module umode_decode (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  umode_checker_pkg::retire_t retire,
  input  logic                       fetch_valid,
  input  logic [`UMC_XLEN-1:0]       fetch_addr,
  output umode_checker_pkg::decoded_t decoded
);

  import umode_checker_pkg::*;

  logic                 has_fetched;
  logic [`UMC_XLEN-1:0] first_fetch_addr;

  insn_u                insn;
  logic [31:0]          insn_word;
  logic [11:0]          csr_addr;
  logic [`UMC_XLEN-1:0] mstatus_post;
  logic                 revoked;
  logic                 classify;
  logic                 is_priv;
  logic                 is_csr;
  logic                 is_mret;
  logic                 is_wfi;
  logic                 is_uret;
  logic                 is_custom;
  logic                 in_umode;
  logic                 tw;
  logic                 illegal_list;
  decoded_t             decoded_d;

  // Fetch window since the last valid record
  // A fetch together with a record opens the next window
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      has_fetched <= 1'b0;
    end else if (retire.valid) begin
      has_fetched <= fetch_valid;
    end else if (fetch_valid) begin
      has_fetched <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_valid && (retire.valid || !has_fetched)) begin
      first_fetch_addr <= fetch_addr;
    end
  end

  assign insn      = retire.insn;
  assign insn_word = retire.insn;
  assign csr_addr  = insn.csr_fmt.csr;
  assign in_umode  = (retire.mode == `UMC_MODE_U);
  assign tw        = retire.mstatus_rdata[`UMC_MSTATUS_TW];

  // Fetch faults mean the instruction never really executed
  assign revoked  = retire.trap.valid && retire.trap.exception &&
                    (retire.trap.cause inside {`UMC_EXC_INSTR_FAULT, `UMC_EXC_INSTR_BUS_FAULT});
  assign classify = retire.valid && !revoked;

  assign is_priv   = classify && (insn.sys_fmt.opcode == `UMC_OPC_SYSTEM) &&
                     (insn.sys_fmt.funct3 == 3'b000);
  assign is_mret   = is_priv && (insn_word == `UMC_INSN_MRET);
  assign is_wfi    = is_priv && (insn_word == `UMC_INSN_WFI);
  assign is_uret   = is_priv && (insn_word == `UMC_INSN_URET);
  assign is_custom = is_priv && (((insn_word & `UMC_CUSTOM_MASK) == `UMC_CUSTOM0) ||
                                 ((insn_word & `UMC_CUSTOM_MASK) == `UMC_CUSTOM1));
  assign is_csr    = classify && (insn.csr_fmt.opcode == `UMC_OPC_SYSTEM) &&
                     (insn.csr_fmt.funct3 inside {3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7});

  // Everything the core has to reject as an illegal instruction
  assign illegal_list =
      is_custom || is_uret ||
      (is_mret && in_umode) ||
      (is_wfi && in_umode && tw) ||
      (is_csr && in_umode && (csr_addr[9:8] != `UMC_MODE_U)) ||
      (is_csr && (csr_addr inside {`UMC_CSR_USTATUS, `UMC_CSR_UIE, `UMC_CSR_UTVEC,
                                   `UMC_CSR_USCRATCH, `UMC_CSR_UEPC, `UMC_CSR_UCAUSE,
                                   `UMC_CSR_UTVAL, `UMC_CSR_UIP})) ||
      (is_csr && (csr_addr inside {`UMC_CSR_MEDELEG, `UMC_CSR_MIDELEG})) ||
      (is_csr && (csr_addr == `UMC_CSR_CYCLE) && in_umode &&
       !retire.mcounteren_rdata[`UMC_MCOUNTEREN_CY]);

  // mstatus as it stands after this retirement
  assign mstatus_post = (retire.mstatus_wdata & retire.mstatus_wmask) |
                        (retire.mstatus_rdata & ~retire.mstatus_wmask);

  always_comb begin
    decoded_d                  = '0;
    decoded_d.valid            = retire.valid;
    decoded_d.mode             = retire.mode;
    decoded_d.trapped          = retire.trap.valid;
    decoded_d.illegal_trapped  = retire.trap.valid && retire.trap.exception &&
                                 (retire.trap.cause == `UMC_EXC_ILLEGAL_INSN);
    decoded_d.must_be_illegal  = illegal_list;
    decoded_d.wfi_free         = is_wfi && in_umode && !tw;
    decoded_d.is_mret          = is_mret;
    decoded_d.mpp              = retire.mstatus_rdata[`UMC_MSTATUS_MPP];
    decoded_d.post_mpp         = mstatus_post[`UMC_MSTATUS_MPP];
    decoded_d.post_mprv        = mstatus_post[`UMC_MSTATUS_MPRV];
    decoded_d.misa_ok          = retire.misa[`UMC_MISA_U] && !retire.misa[`UMC_MISA_S] &&
                                 !retire.misa[`UMC_MISA_N];
    decoded_d.status_ok        =
        (retire.mstatus_rdata[`UMC_MSTATUS_MPP] inside {`UMC_MODE_U, `UMC_MODE_M}) &&
        !retire.mstatus_rdata[`UMC_MSTATUS_SPP] &&
        (retire.mstatus_rdata[`UMC_MSTATUS_XS] == 2'b00) &&
        (retire.mstatus_rdata[`UMC_MSTATUS_FS] == 2'b00) &&
        !retire.mstatus_rdata[`UMC_MSTATUS_SD];
    decoded_d.mscratch_written = |retire.mscratch_wmask;
    // Window state before this edge belongs to this record
    decoded_d.refetched        = has_fetched && (first_fetch_addr == retire.pc);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      decoded <= '0;
    end else begin
      decoded <= decoded_d;
    end
  end

endmodule

// File: verilog/umode_checker_pkg.sv
`include "umode_checker_params.svh"

package umode_checker_pkg;

  typedef logic [1:0] mode_t;

  typedef struct packed {
    logic       valid;
    logic       exception;
    logic [5:0] cause;
  } trap_t;

  // One instruction word, seen as a CSR access or as a plain SYSTEM encoding
  typedef union packed {
    struct packed {
      logic [11:0] csr;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } csr_fmt;
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } sys_fmt;
  } insn_u;

  // One retirement record from the core trace
  typedef struct packed {
    logic                 valid;
    mode_t                mode;
    insn_u                insn;
    trap_t                trap;
    logic [`UMC_XLEN-1:0] pc;
    logic [`UMC_XLEN-1:0] misa;
    logic [`UMC_XLEN-1:0] mstatus_rdata;
    logic [`UMC_XLEN-1:0] mstatus_wdata;
    logic [`UMC_XLEN-1:0] mstatus_wmask;
    logic [`UMC_XLEN-1:0] mcounteren_rdata;
    logic [`UMC_XLEN-1:0] mscratch_wmask;
  } retire_t;

  typedef enum logic [3:0] {
    RULE_MISA,
    RULE_MODE,
    RULE_STATUS,
    RULE_MSCRATCH,
    RULE_ILLEGAL,
    RULE_WFI_OK,
    RULE_TRAP_MMODE,
    RULE_MRET_MODE,
    RULE_MRET_STATE,
    RULE_REFETCH
  } rule_e;

  typedef logic [`UMC_NUM_RULES-1:0] rule_vec_t;
  typedef logic [`UMC_CNT_W-1:0]     count_t;

  // Classified record, decode to execute
  typedef struct packed {
    logic  valid;
    mode_t mode;
    logic  trapped;
    logic  illegal_trapped;
    logic  must_be_illegal;
    logic  wfi_free;
    logic  is_mret;
    mode_t mpp;
    mode_t post_mpp;
    logic  post_mprv;
    logic  misa_ok;
    logic  status_ok;
    logic  mscratch_written;
    logic  refetched;
  } decoded_t;

  typedef struct packed {
    logic      valid;
    rule_vec_t rules;
  } verdict_t;

endpackage

// File: verilog/umode_checker_params.svh
`ifndef UMODE_CHECKER_PARAMS_SVH
`define UMODE_CHECKER_PARAMS_SVH

// Widths
`define UMC_XLEN       32
`define UMC_CNT_W      16
`define UMC_NUM_RULES  10

// Privilege modes, only U and M are implemented
`define UMC_MODE_U  2'b00
`define UMC_MODE_M  2'b11

// mstatus fields
`define UMC_MSTATUS_MPP   12:11
`define UMC_MSTATUS_SPP   8
`define UMC_MSTATUS_MPRV  17
`define UMC_MSTATUS_TW    21
`define UMC_MSTATUS_FS    14:13
`define UMC_MSTATUS_XS    16:15
`define UMC_MSTATUS_SD    31

// misa extension bits
`define UMC_MISA_U  20
`define UMC_MISA_S  18
`define UMC_MISA_N  13

`define UMC_MCOUNTEREN_CY  0

// Instruction encodings
`define UMC_OPC_SYSTEM    7'b1110011
`define UMC_INSN_MRET     32'h3020_0073
`define UMC_INSN_WFI      32'h1050_0073
`define UMC_INSN_URET     32'h0020_0073
`define UMC_CUSTOM0       32'h8C00_0073
`define UMC_CUSTOM1       32'hCC00_0073
`define UMC_CUSTOM_MASK   32'hFC00_707F

// CSR addresses
`define UMC_CSR_USTATUS   12'h000
`define UMC_CSR_UIE       12'h004
`define UMC_CSR_UTVEC     12'h005
`define UMC_CSR_USCRATCH  12'h040
`define UMC_CSR_UEPC      12'h041
`define UMC_CSR_UCAUSE    12'h042
`define UMC_CSR_UTVAL     12'h043
`define UMC_CSR_UIP       12'h044
`define UMC_CSR_CYCLE     12'hC00
`define UMC_CSR_MEDELEG   12'h302
`define UMC_CSR_MIDELEG   12'h303

// Exception causes
`define UMC_EXC_INSTR_FAULT      6'd1
`define UMC_EXC_ILLEGAL_INSN     6'd2
`define UMC_EXC_INSTR_BUS_FAULT  6'd24

`endif
